/* tb.f */
+incdir+logic
logic/row_engine_pkg.sv
logic/dram_row_packer.sv
logic/row_buffer_ram.sv
logic/row_mac.sv
logic/row_engine_top.sv
sim/tb_row_engine.sv

/* run_sim.sh */
#!/bin/sh
# build and run the row engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_row_engine -o tb_row_engine

./obj_dir/tb_row_engine 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* sim/tb_row_engine.sv */
`timescale 1ns/10ps
`include "row_engine_consts.svh"

module tb_row_engine;

    localparam int ENTRIES = 20;

    typedef struct packed {
        row_engine_pkg::row_t  feature;
        row_engine_pkg::row_t  weight;
        logic                  interleave;
        row_engine_pkg::psum_t expected;
    } entry_s;

    logic                       clk_i;
    logic                       rd_weight_rst;
    row_engine_pkg::dram_beat_s beat_i;
    row_engine_pkg::mac_req_s   req_i;
    row_engine_pkg::psum_t      result_o;
    logic                       result_valid_o;

    entry_s                    table_q [ENTRIES];
    row_engine_pkg::row_addr_t addr_q [ENTRIES];
    row_engine_pkg::psum_t     exp_q [$];
    int                        strobe_q [$];
    int                        seed = 32'hd1e7;
    int                        cycle_cnt = 0;
    int                        rows_sent;
    int                        errors = 0;
    int                        test_errors;
    int                        tests_run = 0;
    int                        tests_bad = 0;

    row_engine_top row_engine_top_inst (
        .clk_i(clk_i),
        .rd_weight_rst(rd_weight_rst),
        .beat_i(beat_i),
        .req_i(req_i),
        .result_o(result_o),
        .result_valid_o(result_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic row_engine_pkg::psum_t dot_product(input row_engine_pkg::row_t f,
                                                          input row_engine_pkg::row_t w);
        int acc;
        acc = 0;
        for (int k = 0; k < `ROW_LANES; k++) begin
            acc += int'(row_engine_pkg::lane_t'(f[k*`LANE_WIDTH +: `LANE_WIDTH])) *
                   int'(row_engine_pkg::lane_t'(w[k*`LANE_WIDTH +: `LANE_WIDTH]));
        end
        // keep the low 16 bits only
        return row_engine_pkg::psum_t'(acc);
    endfunction

    function automatic row_engine_pkg::row_t random_row();
        row_engine_pkg::row_t r;
        for (int k = 0; k < `ROW_LANES; k++) begin
            r[k*`LANE_WIDTH +: `LANE_WIDTH] = 8'($random(seed));
        end
        return r;
    endfunction

    task automatic report_mismatch(input string sig, input int exp, input int got);
        $display("[FAIL] %0t: %s expected %0d, got %0d", $time, sig, exp, got);
        errors++;
    endtask

    task automatic send_beat(input row_engine_pkg::beat_target_e t, input row_engine_pkg::beat_t b);
        @(posedge clk_i);
        beat_i <= '{beat: b, target: t, valid: 1'b1};
    endtask

    // one feature row and one weight row landing at the same row address
    task automatic send_pair(input row_engine_pkg::row_t f, input row_engine_pkg::row_t w,
                             input logic interleave, output row_engine_pkg::row_addr_t a);
        logic [`BEAT_WIDTH*`BEATS_PER_ROW-1:0] fw;
        logic [`BEAT_WIDTH*`BEATS_PER_ROW-1:0] ww;
        // junk in the top byte that the packer drops
        fw = {8'($random(seed)), f};
        ww = {8'($random(seed)), w};
        for (int k = 0; k < `BEATS_PER_ROW; k++) begin
            send_beat(row_engine_pkg::FEATURE, fw[k*`BEAT_WIDTH +: `BEAT_WIDTH]);
            if (interleave) send_beat(row_engine_pkg::WEIGHT, ww[k*`BEAT_WIDTH +: `BEAT_WIDTH]);
        end
        for (int k = 0; k < `BEATS_PER_ROW && !interleave; k++) begin
            send_beat(row_engine_pkg::WEIGHT, ww[k*`BEAT_WIDTH +: `BEAT_WIDTH]);
        end
        @(posedge clk_i);
        beat_i <= '0;
        a = row_engine_pkg::row_addr_t'(rows_sent);
        rows_sent++;
    endtask

    task automatic issue_compute(input row_engine_pkg::row_addr_t fa,
                                 input row_engine_pkg::row_addr_t wa,
                                 input row_engine_pkg::psum_t exp);
        @(posedge clk_i);
        req_i <= '{strobe: 1'b1, feature_addr: fa, weight_addr: wa};
        exp_q.push_back(exp);
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(posedge clk_i);
        req_i <= '0;
        while (exp_q.size() > 0 && waited < 20) begin
            @(posedge clk_i);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("error at %0t: %s timed out waiting for result_valid_o", $time, name);
            errors++;
            exp_q.delete();
            strobe_q.delete();
        end
        tests_run++;
        if (errors > test_errors) tests_bad++;
        $display("%-24s %s", name, (errors > test_errors) ? "failed" : "passed");
        test_errors = errors;
    endtask

    // results come back in strobe order MAC_LATENCY cycles after their strobe
    always @(negedge clk_i) begin
        int lat;
        if (req_i.strobe) strobe_q.push_back(cycle_cnt);
        if (result_valid_o) begin
            assert (exp_q.size() > 0) else begin
                $display("error at %0t: result_valid_o pulsed with nothing pending", $time);
                errors++;
            end
            if (exp_q.size() > 0) begin
                lat = cycle_cnt - strobe_q.pop_front();
                assert (lat == `MAC_LATENCY) else report_mismatch("latency", `MAC_LATENCY, lat);
                assert (result_o == exp_q[0]) else
                    report_mismatch("result_o", int'(exp_q[0]), int'(result_o));
                void'(exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        entry_s                    e;
        row_engine_pkg::row_t      f;
        row_engine_pkg::row_addr_t a;
        int                        w_idx;
        rd_weight_rst = 1'b1;
        beat_i        = '0;
        req_i         = '0;
        rows_sent     = 0;
        test_errors   = 0;

        // extreme lanes in the first three entries
        for (int i = 0; i < ENTRIES; i++) begin
            e.feature    = (i < 2) ? {`ROW_LANES{8'h80}} :
                           (i == 2) ? {`ROW_LANES{8'h7f}} : random_row();
            e.weight     = (i == 0) ? {`ROW_LANES{8'h80}} :
                           (i < 3) ? {`ROW_LANES{8'h7f}} : random_row();
            e.interleave = 1'($random(seed));
            e.expected   = dot_product(e.feature, e.weight);
            table_q[i]   = e;
        end

        for (int c = 0; c < 11; c++) begin
            @(posedge clk_i);
            if (c == 7) rd_weight_rst <= 1'b0;
            @(negedge clk_i);
            assert (result_valid_o == 1'b0) else
                report_mismatch("result_valid_o", 0, int'(result_valid_o));
            assert (result_o == '0) else report_mismatch("result_o", 0, int'(result_o));
        end
        finish_test("reset");

        // unit weight in lane j picks out feature lane j
        f = random_row();
        for (int j = 0; j < `ROW_LANES; j++) begin
            send_pair(f, row_engine_pkg::row_t'(1) << (j * `LANE_WIDTH), 1'(j), a);
            issue_compute(a, a, row_engine_pkg::psum_t'(
                row_engine_pkg::lane_t'(f[j*`LANE_WIDTH +: `LANE_WIDTH])));
            finish_test($sformatf("lane_pack_%0d", j));
        end

        // row addresses wrap partway through the table
        for (int i = 0; i < ENTRIES; i++) begin
            send_pair(table_q[i].feature, table_q[i].weight, table_q[i].interleave, a);
            addr_q[i] = a;
            issue_compute(a, a, table_q[i].expected);
            finish_test($sformatf("entry_%0d_row_%0d", i, a));
        end

        // each feature row meets the weight row of another entry
        for (int i = ENTRIES - 4; i < ENTRIES; i++) begin
            w_idx = 2 * ENTRIES - 5 - i;
            issue_compute(addr_q[i], addr_q[w_idx],
                          dot_product(table_q[i].feature, table_q[w_idx].weight));
        end
        finish_test("pipeline");

        // half a row then reset so the next full row lands at row 0
        send_beat(row_engine_pkg::FEATURE, 32'($random(seed)));
        send_beat(row_engine_pkg::FEATURE, 32'($random(seed)));
        @(posedge clk_i);
        beat_i        <= '0;
        rd_weight_rst <= 1'b1;
        repeat (2) @(posedge clk_i);
        rd_weight_rst <= 1'b0;
        rows_sent = 0;
        send_pair(table_q[3].feature, table_q[3].weight, 1'b0, a);
        issue_compute(a, a, table_q[3].expected);
        finish_test("mid_row_reset");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* logic/row_engine_top.sv */
`timescale 1ns/10ps

module row_engine_top (
    input  logic                       clk_i,
    input  logic                       rd_weight_rst,
    input  row_engine_pkg::dram_beat_s beat_i,
    input  row_engine_pkg::mac_req_s   req_i,
    output row_engine_pkg::psum_t      result_o,
    output logic                       result_valid_o
);

    row_engine_pkg::row_write_s feature_wr;
    row_engine_pkg::row_write_s weight_wr;
    logic                       feature_rd_en;
    logic                       weight_rd_en;
    row_engine_pkg::row_addr_t  feature_rd_addr;
    row_engine_pkg::row_addr_t  weight_rd_addr;
    row_engine_pkg::row_t       feature_row;
    row_engine_pkg::row_t       weight_row;

    //////////////////////////////////////////////////////////////////////
    // feature path
    //////////////////////////////////////////////////////////////////////

    dram_row_packer #(
        .PACK_TARGET(row_engine_pkg::FEATURE)
    ) feature_packer (
        .clk_i(clk_i),
        .rd_weight_rst(rd_weight_rst),
        .beat_i(beat_i),
        .row_wr_o(feature_wr)
    );

    row_buffer_ram feature_mem (
        .clk_i(clk_i),
        .row_wr_i(feature_wr),
        .rd_en_i(feature_rd_en),
        .rd_addr_i(feature_rd_addr),
        .rd_row_o(feature_row)
    );

    //////////////////////////////////////////////////////////////////////
    // weight path
    //////////////////////////////////////////////////////////////////////

    dram_row_packer #(
        .PACK_TARGET(row_engine_pkg::WEIGHT)
    ) weight_packer (
        .clk_i(clk_i),
        .rd_weight_rst(rd_weight_rst),
        .beat_i(beat_i),
        .row_wr_o(weight_wr)
    );

    row_buffer_ram weight_mem (
        .clk_i(clk_i),
        .row_wr_i(weight_wr),
        .rd_en_i(weight_rd_en),
        .rd_addr_i(weight_rd_addr),
        .rd_row_o(weight_row)
    );

    // dot product of one feature row against one weight row
    row_mac mac (
        .clk_i(clk_i),
        .rd_weight_rst(rd_weight_rst),
        .req_i(req_i),
        .feature_rd_en_o(feature_rd_en),
        .weight_rd_en_o(weight_rd_en),
        .feature_rd_addr_o(feature_rd_addr),
        .weight_rd_addr_o(weight_rd_addr),
        .feature_row_i(feature_row),
        .weight_row_i(weight_row),
        .result_o(result_o),
        .result_valid_o(result_valid_o)
    );

endmodule

/* logic/row_mac.sv */
`timescale 1ns/10ps
`include "row_engine_consts.svh"

module row_mac (
    input  logic                      clk_i,
    input  logic                      rd_weight_rst,
    input  row_engine_pkg::mac_req_s  req_i,
    output logic                      feature_rd_en_o,
    output logic                      weight_rd_en_o,
    output row_engine_pkg::row_addr_t feature_rd_addr_o,
    output row_engine_pkg::row_addr_t weight_rd_addr_o,
    input  row_engine_pkg::row_t      feature_row_i,
    input  row_engine_pkg::row_t      weight_row_i,
    output row_engine_pkg::psum_t     result_o,
    output logic                      result_valid_o
);

    row_engine_pkg::row_t  feature_q;
    row_engine_pkg::row_t  weight_q;
    row_engine_pkg::psum_t prod_q [`ROW_LANES];
    row_engine_pkg::psum_t sum_c;
    logic [2:0]            valid_q;

    // both memories read in the strobe cycle
    assign feature_rd_en_o   = req_i.strobe;
    assign weight_rd_en_o    = req_i.strobe;
    assign feature_rd_addr_o = req_i.feature_addr;
    assign weight_rd_addr_o  = req_i.weight_addr;

    // one bit per stage, new strobe every cycle allowed
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[1:0], req_i.strobe};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage one: weight register and matching feature row
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            weight_q  <= '0;
            feature_q <= '0;
        end else if (valid_q[0]) begin
            weight_q  <= weight_row_i;
            feature_q <= feature_row_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage two: signed lane products
    //////////////////////////////////////////////////////////////////////

    // 8x8 signed always fits 16 bits
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            for (int k = 0; k < `ROW_LANES; k++) begin
                prod_q[k] <= '0;
            end
        end else if (valid_q[1]) begin
            for (int k = 0; k < `ROW_LANES; k++) begin
                prod_q[k] <= row_engine_pkg::lane_t'(feature_q[k*`LANE_WIDTH +: `LANE_WIDTH]) *
                             row_engine_pkg::lane_t'(weight_q[k*`LANE_WIDTH +: `LANE_WIDTH]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage three: lane sum, wraps at 16 bits
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sum_c = '0;
        for (int k = 0; k < `ROW_LANES; k++) begin
            sum_c = sum_c + prod_q[k];
        end
    end

    assign result_o       = sum_c;
    assign result_valid_o = valid_q[2];

    // valid pulses exactly MAC_LATENCY cycles after each strobe, never otherwise
    a_result_latency: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        result_valid_o == $past(req_i.strobe, `MAC_LATENCY));

    // memories were written before use, so no X may reach the result
    a_result_known: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        result_valid_o |-> !$isunknown(result_o));

endmodule

/* logic/row_buffer_ram.sv */
`timescale 1ns/10ps
`include "row_engine_consts.svh"

module row_buffer_ram (
    input  logic                       clk_i,
    input  row_engine_pkg::row_write_s row_wr_i,
    input  logic                       rd_en_i,
    input  row_engine_pkg::row_addr_t  rd_addr_i,
    output row_engine_pkg::row_t       rd_row_o
);

    row_engine_pkg::row_t mem_q [`ROW_DEPTH];
    row_engine_pkg::row_t rd_row_q;

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (row_wr_i.wr_en) begin
            mem_q[row_wr_i.addr] <= row_wr_i.row;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    // data one cycle after the enable, held otherwise
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_row_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_row_o = rd_row_q;

endmodule

/* logic/dram_row_packer.sv */
`timescale 1ns/10ps
`include "row_engine_consts.svh"

module dram_row_packer #(
    parameter row_engine_pkg::beat_target_e PACK_TARGET = row_engine_pkg::FEATURE
) (
    input  logic                       clk_i,
    input  logic                       rd_weight_rst,
    input  row_engine_pkg::dram_beat_s beat_i,
    output row_engine_pkg::row_write_s row_wr_o
);

    localparam int FILL_WIDTH = `BEAT_WIDTH * `BEATS_PER_ROW;
    localparam int ROW_WIDTH  = `ROW_LANES * `LANE_WIDTH;
    localparam int CNT_WIDTH  = $clog2(`BEATS_PER_ROW + 1);

    row_engine_pkg::pack_state_e state_q;
    logic [CNT_WIDTH-1:0]        beat_cnt_q;
    logic [FILL_WIDTH-1:0]       fill_q;
    logic                        wr_q;
    row_engine_pkg::row_addr_t   row_addr_q;
    logic                        beat_take;
    logic                        last_beat;

    // only beats tagged for this memory count
    assign beat_take = beat_i.valid && (beat_i.target == PACK_TARGET);
    assign last_beat = beat_take && (beat_cnt_q == CNT_WIDTH'(`BEATS_PER_ROW - 1));

    //////////////////////////////////////////////////////////////////////
    // beat counter FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q    <= row_engine_pkg::IDLE;
            beat_cnt_q <= '0;
        end else if (beat_take) begin
            case (state_q)
                row_engine_pkg::IDLE: begin
                    state_q    <= row_engine_pkg::FILLING;
                    beat_cnt_q <= CNT_WIDTH'(1);
                end
                default: begin
                    if (last_beat) begin
                        state_q    <= row_engine_pkg::IDLE;
                        beat_cnt_q <= '0;
                    end else begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                end
            endcase
        end
    end

    // newest beat enters at the top so beat k ends up at bits 32k
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            fill_q <= '0;
        end else if (beat_take) begin
            fill_q <= {beat_i.beat, fill_q[FILL_WIDTH-1:`BEAT_WIDTH]};
        end
    end

    // strobe one cycle after the last beat and address moves on after it
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            wr_q       <= 1'b0;
            row_addr_q <= '0;
        end else begin
            wr_q <= last_beat;
            if (wr_q) begin
                row_addr_q <= row_addr_q + 1'b1;
            end
        end
    end

    assign row_wr_o = '{wr_en: wr_q, addr: row_addr_q, row: fill_q[ROW_WIDTH-1:0]};

    // count stays in range and is zero whenever the FSM is idle
    a_beat_cnt_range: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        (beat_cnt_q <= CNT_WIDTH'(`BEATS_PER_ROW - 1)) &&
        ((state_q != row_engine_pkg::IDLE) || (beat_cnt_q == '0)));

endmodule

/* logic/row_engine_pkg.sv */
`include "row_engine_consts.svh"

package row_engine_pkg;

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`BEAT_WIDTH-1:0] beat_t;
    typedef logic signed [`LANE_WIDTH-1:0] lane_t;
    // lane 0 sits in the lowest bits
    typedef logic [`ROW_LANES*`LANE_WIDTH-1:0] row_t;
    typedef logic [`ROW_ADDR_WIDTH-1:0] row_addr_t;
    typedef logic signed [2*`LANE_WIDTH-1:0] psum_t;

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [0:0] {
        FEATURE = 1'b0,
        WEIGHT  = 1'b1
    } beat_target_e;

    typedef enum logic [0:0] {
        IDLE    = 1'b0,
        FILLING = 1'b1
    } pack_state_e;

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        beat_t        beat;
        beat_target_e target;
        logic         valid;
    } dram_beat_s;

    typedef struct packed {
        logic      wr_en;
        row_addr_t addr;
        row_t      row;
    } row_write_s;

    typedef struct packed {
        logic      strobe;
        row_addr_t feature_addr;
        row_addr_t weight_addr;
    } mac_req_s;

endpackage

/* logic/row_engine_consts.svh */
`ifndef ROW_ENGINE_CONSTS_SVH
`define ROW_ENGINE_CONSTS_SVH

// lanes in one feature or weight row
`define ROW_LANES 15

// bits per lane, signed
`define LANE_WIDTH 8

// width of one DRAM beat
`define BEAT_WIDTH 32

// four beats give 128 bits, the top byte of the last beat is dropped
`define BEATS_PER_ROW 4

// row memory addressing
`define ROW_ADDR_WIDTH 4
`define ROW_DEPTH (1 << `ROW_ADDR_WIDTH)

// compute strobe to result valid
`define MAC_LATENCY 3

`endif
